//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = sram_tb
FILELIST  = build.f
PASS_MSG  = Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- build.f
logic/sram_pkg.sv
logic/host_pkg.sv
logic/sram_timing_regs.sv
logic/req_queue.sv
logic/sram_sequencer.sv
logic/sram_ctrl_top.sv
tests/sram_board_model.sv
tests/sram_checker.sv
tests/sram_tb.sv

//--- logic/host_pkg.sv
// Host side definitions for the SRAM controller.
// Request opcodes, timing register selects and host widths.
`default_nettype none

package host_pkg;

   parameter int host_data_w = 32;
   parameter int host_mask_w = 4;  // One bit per byte of the host word.

   // Wait-state counts.
   parameter int wait_w = 4;
   parameter logic [wait_w-1:0] wait_reset = 4'd2;

   typedef enum logic
   {
      op_read  = 1'b0,
      op_write = 1'b1
   } host_op_t;

   // Timing register select on the config port.
   typedef enum logic
   {
      cfg_read_wait  = 1'b0,
      cfg_write_wait = 1'b1
   } cfg_sel_t;

endpackage

`default_nettype wire

//--- logic/req_queue.sv
// Host request queue.
// Circular FIFO between the host and the pin sequencer, returning
// one credit to the host for every entry it hands on.
`timescale 1ns/1ps
`default_nettype none

module req_queue
   import host_pkg::*;
   import sram_pkg::*;
#(
   parameter int queue_depth = 4
)
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   req_valid,
   input  host_op_t               req_op,
   input  logic [sram_addr_w-1:0] req_addr,
   input  logic [host_mask_w-1:0] req_mask,
   input  logic [host_data_w-1:0] req_wdata,
   input  logic                   q_pop,
   output logic                   q_valid,
   output host_op_t               q_op,
   output logic [sram_addr_w-1:0] q_addr,
   output logic [host_mask_w-1:0] q_mask,
   output logic [host_data_w-1:0] q_wdata,
   output logic                   credit_return
);

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);

   host_op_t               op_mem    [queue_depth];
   logic [sram_addr_w-1:0] addr_mem  [queue_depth];
   logic [host_mask_w-1:0] mask_mem  [queue_depth];
   logic [host_data_w-1:0] wdata_mem [queue_depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] fill;
   logic             pop;

   assign q_valid = (fill != '0);
   assign pop     = q_pop && q_valid;

   // Head entry.
   assign q_op    = op_mem[rd_ptr];
   assign q_addr  = addr_mem[rd_ptr];
   assign q_mask  = mask_mem[rd_ptr];
   assign q_wdata = wdata_mem[rd_ptr];

   always_ff @(posedge clk)
      if (req_valid)
      begin
         op_mem[wr_ptr]    <= req_op;
         addr_mem[wr_ptr]  <= req_addr;
         mask_mem[wr_ptr]  <= req_mask;
         wdata_mem[wr_ptr] <= req_wdata;
      end

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         fill          <= '0;
         credit_return <= 1'b0;
      end
      else
      begin
         credit_return <= pop;  // One cycle after the pop.
         if (req_valid)
            wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
         case ({req_valid, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end

endmodule

`default_nettype wire

//--- logic/sram_ctrl_top.sv
// SRAM controller top level.
// Presents the two 256K x 16 chips as one 256K x 32 memory to a
// credit-flow host; queue, timing registers and pin sequencer.
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_top
   import host_pkg::*;
   import sram_pkg::*;
#(
   parameter int queue_depth = 4
)
(
   input  logic                   clk,
   input  logic                   arst_n,

   input  logic                   req_valid,
   input  host_op_t               req_op,
   input  logic [sram_addr_w-1:0] req_addr,
   input  logic [host_mask_w-1:0] req_mask,
   input  logic [host_data_w-1:0] req_wdata,
   output logic                   credit_return,
   output logic                   rsp_valid,
   output logic [host_data_w-1:0] rsp_data,

   input  logic                   cfg_we,
   input  cfg_sel_t               cfg_sel,
   input  logic [wait_w-1:0]      cfg_wdata,

   output logic [sram_addr_w-1:0] ram_a,
   output logic                   ram_oe_n,
   output logic                   ram_we_n,
   inout  wire  [sram_data_w-1:0] ram1_io,
   output logic                   ram1_ce_n,
   output logic                   ram1_ub_n,
   output logic                   ram1_lb_n,
   inout  wire  [sram_data_w-1:0] ram2_io,
   output logic                   ram2_ce_n,
   output logic                   ram2_ub_n,
   output logic                   ram2_lb_n
);

   logic                   q_valid;
   logic                   q_pop;
   host_op_t               q_op;
   logic [sram_addr_w-1:0] q_addr;
   logic [host_mask_w-1:0] q_mask;
   logic [host_data_w-1:0] q_wdata;
   logic [wait_w-1:0]      read_wait;
   logic [wait_w-1:0]      write_wait;

   req_queue #(
      .queue_depth (queue_depth)
   ) i_queue (
      .clk           (clk),
      .arst_n        (arst_n),
      .req_valid     (req_valid),
      .req_op        (req_op),
      .req_addr      (req_addr),
      .req_mask      (req_mask),
      .req_wdata     (req_wdata),
      .q_pop         (q_pop),
      .q_valid       (q_valid),
      .q_op          (q_op),
      .q_addr        (q_addr),
      .q_mask        (q_mask),
      .q_wdata       (q_wdata),
      .credit_return (credit_return)
   );

   sram_timing_regs i_timing (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg_we     (cfg_we),
      .cfg_sel    (cfg_sel),
      .cfg_wdata  (cfg_wdata),
      .read_wait  (read_wait),
      .write_wait (write_wait)
   );

   sram_sequencer i_seq (
      .clk        (clk),
      .arst_n     (arst_n),
      .q_valid    (q_valid),
      .q_op       (q_op),
      .q_addr     (q_addr),
      .q_mask     (q_mask),
      .q_wdata    (q_wdata),
      .q_pop      (q_pop),
      .read_wait  (read_wait),
      .write_wait (write_wait),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .ram_a      (ram_a),
      .ram_oe_n   (ram_oe_n),
      .ram_we_n   (ram_we_n),
      .ram1_io    (ram1_io),
      .ram1_ce_n  (ram1_ce_n),
      .ram1_ub_n  (ram1_ub_n),
      .ram1_lb_n  (ram1_lb_n),
      .ram2_io    (ram2_io),
      .ram2_ce_n  (ram2_ce_n),
      .ram2_ub_n  (ram2_ub_n),
      .ram2_lb_n  (ram2_lb_n)
   );

endmodule

`default_nettype wire

//--- logic/sram_pkg.sv
// SRAM side definitions for the dual 256K x 16 board memory.
// Pin widths, byte lanes per chip and the pin sequencer states.
`default_nettype none

package sram_pkg;

   parameter int sram_addr_w = 18;  // Word address of one chip.
   parameter int sram_data_w = 16;  // One chip's data bus.
   parameter int sram_chips  = 2;
   parameter int sram_lanes  = 2;   // Byte lanes per chip.

   // Pin sequencer states.
   typedef enum logic [2:0]
   {
      st_idle,
      st_setup,
      st_read,
      st_write,
      st_turn
   } seq_state_t;

endpackage

`default_nettype wire

//--- logic/sram_sequencer.sv
// SRAM pin sequencer.
// Runs one read or write cycle at a time on the two 16-bit chips,
// drives the shared tristate buses and returns read data to the host.
`timescale 1ns/1ps
`default_nettype none

module sram_sequencer
   import host_pkg::*;
   import sram_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,

   input  logic                   q_valid,
   input  host_op_t               q_op,
   input  logic [sram_addr_w-1:0] q_addr,
   input  logic [host_mask_w-1:0] q_mask,
   input  logic [host_data_w-1:0] q_wdata,
   output logic                   q_pop,

   input  logic [wait_w-1:0]      read_wait,
   input  logic [wait_w-1:0]      write_wait,

   output logic                   rsp_valid,
   output logic [host_data_w-1:0] rsp_data,

   output logic [sram_addr_w-1:0] ram_a,
   output logic                   ram_oe_n,
   output logic                   ram_we_n,
   inout  wire  [sram_data_w-1:0] ram1_io,
   output logic                   ram1_ce_n,
   output logic                   ram1_ub_n,
   output logic                   ram1_lb_n,
   inout  wire  [sram_data_w-1:0] ram2_io,
   output logic                   ram2_ce_n,
   output logic                   ram2_ub_n,
   output logic                   ram2_lb_n
);

   seq_state_t             state;
   logic [wait_w-1:0]      cnt;
   host_op_t               op_r;
   logic [sram_addr_w-1:0] addr_r;
   logic [host_mask_w-1:0] mask_r;
   logic [host_data_w-1:0] wdata_r;
   logic                   start;
   logic                   active;
   logic                   is_write;
   logic                   drive_io;
   logic                   sample;
   logic [sram_chips-1:0]  ce_n;
   logic [sram_chips-1:0]  ub_n;
   logic [sram_chips-1:0]  lb_n;
   logic [host_data_w-1:0] rd_word;

   assign start    = (state == st_idle) && q_valid;
   assign q_pop    = start;
   assign active   = (state != st_idle);
   assign is_write = (op_r == op_write);
   assign sample   = (state == st_read) && (cnt == '0);  // Last read cycle.

   // Data driven from setup through turnaround of a write.
   assign drive_io = is_write &&
                     ((state == st_setup) || (state == st_write) || (state == st_turn));

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         state     <= st_idle;
         cnt       <= '0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         rsp_valid <= sample;
         case (state)
            st_idle:
               if (q_valid)
               begin
                  state <= st_setup;
                  cnt   <= (q_op == op_write) ? write_wait : read_wait;
               end
            st_setup:
               state <= is_write ? st_write : st_read;
            st_read:
               if (cnt == '0)
                  state <= st_idle;
               else
                  cnt <= cnt - 1'b1;
            st_write:
               if (cnt == '0)
                  state <= st_turn;
               else
                  cnt <= cnt - 1'b1;
            st_turn:
               state <= st_idle;  // WE high, data still held.
            default:
               state <= st_idle;
         endcase
      end

   // Request fields latched at pop.
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         op_r    <= q_op;
         addr_r  <= q_addr;
         mask_r  <= q_mask;
         wdata_r <= q_wdata;
      end
      if (sample)
         rsp_data <= rd_word;
   end

   // Per-chip enables. Writes enable only the masked lanes.
   for (genvar c = 0; c < sram_chips; c++)
   begin : g_chip
      logic [sram_lanes-1:0] lanes;

      assign lanes   = is_write ? mask_r[c*sram_lanes +: sram_lanes] : '1;
      assign ce_n[c] = !(active && (|lanes));
      assign ub_n[c] = !(active && lanes[1]);
      assign lb_n[c] = !(active && lanes[0]);
   end

   assign ram_a    = addr_r;
   assign ram_oe_n = (state != st_read);
   assign ram_we_n = (state != st_write);

   assign ram1_ce_n = ce_n[0];
   assign ram1_ub_n = ub_n[0];
   assign ram1_lb_n = lb_n[0];
   assign ram2_ce_n = ce_n[1];
   assign ram2_ub_n = ub_n[1];
   assign ram2_lb_n = lb_n[1];

   assign ram1_io = drive_io ? wdata_r[0 +: sram_data_w] : 'z;
   assign ram2_io = drive_io ? wdata_r[sram_data_w +: sram_data_w] : 'z;

   // Chip 2 carries the upper half word.
   assign rd_word = {ram2_io, ram1_io};

endmodule

`default_nettype wire

//--- logic/sram_timing_regs.sv
// SRAM timing registers.
// Holds the read and write wait-state counts, written from the config port.
`timescale 1ns/1ps
`default_nettype none

module sram_timing_regs
   import host_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              cfg_we,
   input  cfg_sel_t          cfg_sel,
   input  logic [wait_w-1:0] cfg_wdata,
   output logic [wait_w-1:0] read_wait,
   output logic [wait_w-1:0] write_wait
);

   logic [wait_w-1:0] read_wait_r;
   logic [wait_w-1:0] write_wait_r;

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         read_wait_r  <= wait_reset;
         write_wait_r <= wait_reset;
      end
      else if (cfg_we)
      begin
         case (cfg_sel)
            cfg_read_wait:
               read_wait_r <= cfg_wdata;
            cfg_write_wait:
               write_wait_r <= cfg_wdata;
         endcase
      end

   // Sampled by the sequencer at pop.
   assign read_wait  = read_wait_r;
   assign write_wait = write_wait_r;

endmodule

`default_nettype wire

//--- tests/sram_board_model.sv
// Board model of the two 256K x 16 asynchronous SRAM chips.
// Byte-lane writes at the end of the WE pulse, whole-word tristate reads.
`timescale 1ns/1ps
`default_nettype none

module sram_board_model
   import sram_pkg::*;
(
   input  wire [sram_addr_w-1:0] ram_a,
   input  wire                   ram_oe_n,
   input  wire                   ram_we_n,
   inout  wire [sram_data_w-1:0] ram1_io,
   input  wire                   ram1_ce_n,
   input  wire                   ram1_ub_n,
   input  wire                   ram1_lb_n,
   inout  wire [sram_data_w-1:0] ram2_io,
   input  wire                   ram2_ce_n,
   input  wire                   ram2_ub_n,
   input  wire                   ram2_lb_n
);

   logic [sram_data_w-1:0] mem1 [2**sram_addr_w];
   logic [sram_data_w-1:0] mem2 [2**sram_addr_w];

   initial
   begin
      for (int i = 0; i < 2**sram_addr_w; i++)
      begin
         mem1[i] = '0;
         mem2[i] = '0;
      end
   end

   // Write completes on the rising edge of WE.
   always @(posedge ram_we_n)
   begin
      if (!ram1_ce_n && !ram1_lb_n)
         mem1[ram_a][7:0] <= ram1_io[7:0];
      if (!ram1_ce_n && !ram1_ub_n)
         mem1[ram_a][15:8] <= ram1_io[15:8];
      if (!ram2_ce_n && !ram2_lb_n)
         mem2[ram_a][7:0] <= ram2_io[7:0];
      if (!ram2_ce_n && !ram2_ub_n)
         mem2[ram_a][15:8] <= ram2_io[15:8];
   end

   assign ram1_io = (!ram1_ce_n && !ram_oe_n && ram_we_n) ? mem1[ram_a] : 'z;
   assign ram2_io = (!ram2_ce_n && !ram_oe_n && ram_we_n) ? mem2[ram_a] : 'z;

endmodule

`default_nettype wire

//--- tests/sram_checker.sv
// Response and credit checker for the SRAM controller.
// Compares read data in order, tracks credits and idle outputs before traffic.
`timescale 1ns/1ps
`default_nettype none

module sram_checker
   import host_pkg::*;
#(
   parameter int queue_depth = 4
)
(
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   req_valid,
   input  wire                   credit_return,
   input  wire                   rsp_valid,
   input  wire [host_data_w-1:0] rsp_data,
   input  wire                   exp_push,
   input  wire [host_data_w-1:0] exp_data,
   input  int                    exp_line,
   input  wire                   ram_oe_n,
   input  wire                   ram_we_n,
   input  wire                   ram1_ce_n,
   input  wire                   ram2_ce_n,
   output int                    errors,
   output int                    pending,
   output int                    outstanding
);

   logic [host_data_w-1:0] exp_q [$];
   int                     line_q [$];
   logic                   seen_req = 1'b0;
   int                     err_cnt = 0;
   int                     out_cnt = 0;
   int                     pend_cnt = 0;

   assign errors      = err_cnt;
   assign pending     = pend_cnt;
   assign outstanding = out_cnt;

   task automatic check_level(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         err_cnt++;
         $display("FAILED reset_state %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   // Sampled mid-cycle, away from the driving edge.
   always @(negedge clk)
   begin : watch
      logic [host_data_w-1:0] expected;
      int                     line_no;

      if (!seen_req)
      begin
         check_level("rsp_valid", 1'b0, rsp_valid);
         check_level("credit_return", 1'b0, credit_return);
         check_level("ram_oe_n", 1'b1, ram_oe_n);
         check_level("ram_we_n", 1'b1, ram_we_n);
         check_level("ram1_ce_n", 1'b1, ram1_ce_n);
         check_level("ram2_ce_n", 1'b1, ram2_ce_n);
      end
      if (arst_n)
      begin
         if (req_valid)
            seen_req = 1'b1;
         if (exp_push)
         begin
            exp_q.push_back(exp_data);
            line_q.push_back(exp_line);
         end
         if (rsp_valid && exp_q.size() == 0)
         begin
            err_cnt++;
            $display("a read response arrived while no read was pending");
         end
         else if (rsp_valid)
         begin
            expected = exp_q.pop_front();
            line_no  = line_q.pop_front();
            if (rsp_data !== expected)
            begin
               err_cnt++;
               $display("FAILED read at trace line %0d: expected %08h, actual %08h",
                        line_no, expected, rsp_data);
            end
         end
         out_cnt = out_cnt + (req_valid ? 1 : 0) - (credit_return ? 1 : 0);
         if (out_cnt > queue_depth)
         begin
            err_cnt++;
            $display("more requests outstanding than the queue can hold: %0d", out_cnt);
         end
         if (out_cnt < 0)
         begin
            err_cnt++;
            $display("a credit came back with no request outstanding");
         end
         pend_cnt = exp_q.size();
      end
   end

endmodule

`default_nettype wire

//--- tests/sram_tb.sv
// Testbench for the SRAM controller.
// Replays the trace file through the host port under credit flow control.
`timescale 1ns/1ps
`default_nettype none

module sram_tb
   import host_pkg::*;
   import sram_pkg::*;
();

   localparam int queue_depth    = 4;
   localparam int credit_timeout = 200;
   localparam int drain_timeout  = 2000;

   logic                   clk = 1'b0;
   logic                   arst_n;
   logic                   req_valid;
   host_op_t               req_op;
   logic [sram_addr_w-1:0] req_addr;
   logic [host_mask_w-1:0] req_mask;
   logic [host_data_w-1:0] req_wdata;
   logic                   cfg_we;
   cfg_sel_t               cfg_sel;
   logic [wait_w-1:0]      cfg_wdata;
   wire                    credit_return;
   wire                    rsp_valid;
   wire  [host_data_w-1:0] rsp_data;
   wire  [sram_addr_w-1:0] ram_a;
   wire                    ram_oe_n;
   wire                    ram_we_n;
   wire  [sram_data_w-1:0] ram1_io;
   wire                    ram1_ce_n;
   wire                    ram1_ub_n;
   wire                    ram1_lb_n;
   wire  [sram_data_w-1:0] ram2_io;
   wire                    ram2_ce_n;
   wire                    ram2_ub_n;
   wire                    ram2_lb_n;
   logic                   exp_push;
   logic [host_data_w-1:0] exp_data;
   int                     exp_line;
   int                     chk_errors;
   int                     pending;
   int                     outstanding;
   logic [31:0]            lfsr;
   int                     sent;
   int                     returned = 0;
   int                     tb_errors;
   logic                   timed_out;

   always #10 clk = ~clk;

   always @(posedge clk)
      if (credit_return)
         returned <= returned + 1;

   sram_ctrl_top #(
      .queue_depth (queue_depth)
   ) i_dut (
      .clk (clk), .arst_n (arst_n),
      .req_valid (req_valid), .req_op (req_op), .req_addr (req_addr),
      .req_mask (req_mask), .req_wdata (req_wdata), .credit_return (credit_return),
      .rsp_valid (rsp_valid), .rsp_data (rsp_data),
      .cfg_we (cfg_we), .cfg_sel (cfg_sel), .cfg_wdata (cfg_wdata),
      .ram_a (ram_a), .ram_oe_n (ram_oe_n), .ram_we_n (ram_we_n),
      .ram1_io (ram1_io), .ram1_ce_n (ram1_ce_n), .ram1_ub_n (ram1_ub_n), .ram1_lb_n (ram1_lb_n),
      .ram2_io (ram2_io), .ram2_ce_n (ram2_ce_n), .ram2_ub_n (ram2_ub_n), .ram2_lb_n (ram2_lb_n)
   );

   sram_board_model i_board (
      .ram_a (ram_a), .ram_oe_n (ram_oe_n), .ram_we_n (ram_we_n),
      .ram1_io (ram1_io), .ram1_ce_n (ram1_ce_n), .ram1_ub_n (ram1_ub_n), .ram1_lb_n (ram1_lb_n),
      .ram2_io (ram2_io), .ram2_ce_n (ram2_ce_n), .ram2_ub_n (ram2_ub_n), .ram2_lb_n (ram2_lb_n)
   );

   sram_checker #(
      .queue_depth (queue_depth)
   ) i_check (
      .clk (clk), .arst_n (arst_n), .req_valid (req_valid), .credit_return (credit_return),
      .rsp_valid (rsp_valid), .rsp_data (rsp_data),
      .exp_push (exp_push), .exp_data (exp_data), .exp_line (exp_line),
      .ram_oe_n (ram_oe_n), .ram_we_n (ram_we_n),
      .ram1_ce_n (ram1_ce_n), .ram2_ce_n (ram2_ce_n),
      .errors (chk_errors), .pending (pending), .outstanding (outstanding)
   );

   // Fibonacci LFSR, taps 32 22 2 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_gap(output logic [1:0] gap);
      lfsr   = lfsr_step(lfsr);
      gap[0] = lfsr[0];
      lfsr   = lfsr_step(lfsr);
      gap[1] = lfsr[0];
   endtask

   task automatic idle_inputs();
      req_valid <= 1'b0;
      exp_push  <= 1'b0;
      cfg_we    <= 1'b0;
   endtask

   task automatic write_cfg(input logic sel, input logic [wait_w-1:0] value);
      @(posedge clk);
      idle_inputs();
      cfg_we    <= 1'b1;
      cfg_sel   <= cfg_sel_t'(sel);
      cfg_wdata <= value;
      @(posedge clk);
      cfg_we <= 1'b0;
   endtask

   task automatic issue(input host_op_t op, input logic [31:0] a, input logic [31:0] m,
                        input logic [31:0] d, input int line_no);
      logic [1:0] gap;
      int         waited;

      draw_gap(gap);
      waited = 0;
      repeat (gap)
      begin
         @(posedge clk);
         idle_inputs();
      end
      while (queue_depth - sent + returned <= 0 && waited < credit_timeout)
      begin
         @(posedge clk);
         idle_inputs();
         waited++;
      end
      if (waited >= credit_timeout)
      begin
         $display("timed out waiting for a request credit");
         tb_errors++;
         timed_out = 1'b1;
      end
      else
      begin
         @(posedge clk);
         cfg_we    <= 1'b0;
         req_valid <= 1'b1;
         req_op    <= op;
         req_addr  <= a[sram_addr_w-1:0];
         req_mask  <= m[host_mask_w-1:0];
         req_wdata <= d;
         exp_push  <= (op == op_read);  // Expected data rides along with a read.
         exp_data  <= d;
         exp_line  <= line_no;
         sent++;
      end
   endtask

   initial
   begin : main
      int          fd;
      int          n;
      int          line_no;
      int          waited;
      string       line;
      logic [7:0]  kind;
      logic [31:0] f_a;
      logic [31:0] f_m;
      logic [31:0] f_d;

      arst_n    = 1'b0;
      req_valid = 1'b0;
      req_op    = op_read;
      req_addr  = '0;
      req_mask  = '0;
      req_wdata = '0;
      cfg_we    = 1'b0;
      cfg_sel   = cfg_read_wait;
      cfg_wdata = '0;
      exp_push  = 1'b0;
      exp_data  = '0;
      exp_line  = 0;
      lfsr      = 32'h2cf9;
      sent      = 0;
      tb_errors = 0;
      timed_out = 1'b0;

      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      fd = $fopen("tests/sram_trace.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the trace file");
         tb_errors++;
      end
      else
      begin
         line_no = 0;
         while (!timed_out && $fgets(line, fd) != 0)
         begin
            line_no++;
            n = $sscanf(line, "%c %h %h %h", kind, f_a, f_m, f_d);
            if (n == 4 && kind == "C")
               write_cfg(f_a[0], f_d[wait_w-1:0]);
            else if (n == 4 && (kind == "W" || kind == "R"))
               issue((kind == "W") ? op_write : op_read, f_a, f_m, f_d, line_no);
         end
         $fclose(fd);
      end
      @(posedge clk);
      idle_inputs();

      // Drain. All reads answered and all credits back.
      waited = 0;
      while ((pending != 0 || outstanding != 0) && waited < drain_timeout)
      begin
         @(posedge clk);
         waited++;
      end
      if (waited >= drain_timeout)
      begin
         $display("timed out waiting for responses and credits to come back");
         tb_errors++;
      end

      $display("errors: %0d from checker, %0d from testbench", chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/sram_trace.txt
# kind addr mask data: W write, R read with expected data in the data column,
# C config with select in addr (0 read wait, 1 write wait) and the count in data
W 00010 f 12345678
R 00010 0 12345678
W 00020 f aabbccdd
W 00020 5 11223344
W 00030 8 99000000
R 00020 0 aa22cc44
R 00010 0 12345678
R 3ffff 0 00000000
R 00030 0 99000000
C 0 0 0
C 1 0 0
W 00040 f deadbeef
R 00040 0 deadbeef
C 0 0 7
C 1 0 7
W 00041 3 0000cafe
W 00040 2 0000a500
R 00041 0 0000cafe
R 00040 0 deada5ef
